/* filelist.f */
logic/execPkg.sv
logic/execDispatch.sv
logic/intuLane.sv
logic/intuCluster.sv
logic/ldstCluster.sv
logic/executeStage.sv
verification/executeStage_assertions.sv
verification/executeStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module executeStageTb \
	--Mdir obj_dir \
	-f filelist.f

output="$(./obj_dir/VexecuteStageTb 2>&1)" || true
echo "$output"

if grep -q "Finished with no errors" <<< "$output"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

/* verification/executeStageTb.sv */
// ==================================================
// testbench of the execute stage: random warp
// instructions from a fixed seed, a reference model
// of both clusters and per-cycle output checks
// ==================================================
`timescale 1ns/1ps

module executeStageTb;
	import execPkg::*;

	localparam int NUM_LANES    = 4;
	localparam int NUM_INSTS    = 2000;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLE_LIMIT  = 2100;

	logic                              clk = 1'b0;
	logic                              arstN;
	logic                              fuValid;
	instPacketT                        fuPacket;
	logic [NUM_LANES-1:0]              fuMask;
	laneOperandsT [NUM_LANES-1:0]      laneOps;
	logic                              intuValid;
	logic [NUM_LANES-1:0]              intuMask;
	warpIdT                            intuWarp;
	intuResultT [NUM_LANES-1:0]        intuResults;
	logic                              ldstValid;
	logic [NUM_LANES-1:0]              ldstMask;
	warpIdT                            ldstWarp;
	logic                              load;
	logic                              store;
	ldstRequestT [NUM_LANES-1:0]       ldstRequests;

	// model outputs expected one cycle after the drive
	logic                 expIntuValid;
	logic [NUM_LANES-1:0] expIntuMask;
	warpIdT               expIntuWarp;
	regAddrT              expIntuDest;
	dataT                 expIntuData [NUM_LANES];
	logic                 expLdstValid;
	logic [NUM_LANES-1:0] expLdstMask;
	warpIdT               expLdstWarp;
	logic                 expLoad;
	logic                 expStore;
	regAddrT              expLdstDest;
	dataT                 expAddr [NUM_LANES];
	dataT                 expStoreData [NUM_LANES];

	integer seed;
	int     errorCount = 0;
	int     cycleCount = 0;
	int     intuSent = 0;
	int     ldstSent = 0;

	executeStage #(
		.NUM_LANES (NUM_LANES)
	) executeStage_inst (
		.clk            (clk),
		.arstN_i        (arstN),
		.fuValid_i      (fuValid),
		.fuPacket_i     (fuPacket),
		.fuMask_i       (fuMask),
		.laneOps_i      (laneOps),
		.intuValid_o    (intuValid),
		.intuMask_o     (intuMask),
		.intuWarp_o     (intuWarp),
		.intuResults_o  (intuResults),
		.ldstValid_o    (ldstValid),
		.ldstMask_o     (ldstMask),
		.ldstWarp_o     (ldstWarp),
		.load_o         (load),
		.store_o        (store),
		.ldstRequests_o (ldstRequests)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic dataT widenImm(immT imm);
		// negative immediates fill the upper half with ones
		if (imm[IMM_WIDTH-1]) begin
			widenImm = {{(DATA_WIDTH-IMM_WIDTH){1'b1}}, imm};
		end else begin
			widenImm = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm};
		end
	endfunction

	function automatic dataT aluRef(logic [2:0] op, dataT a, dataT b);
		case (op)
			3'd0: aluRef = a + b;
			3'd1: aluRef = a - b;
			3'd2: aluRef = a & b;
			3'd3: aluRef = a | b;
			3'd4: aluRef = a ^ b;
			3'd5: aluRef = a << b[4:0];
			3'd6: aluRef = a >> b[4:0];
			default: aluRef = '0;
		endcase
	endfunction

	task automatic reportMismatch(string what, logic [31:0] got, logic [31:0] exp);
		errorCount++;
		$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic clearExpected();
		expIntuValid = 1'b0;
		expIntuMask  = '0;
		expLdstValid = 1'b0;
		expLdstMask  = '0;
		expLoad      = 1'b0;
		expStore     = 1'b0;
	endtask

	// draws one instruction and works out what each cluster returns for it
	task automatic driveInstruction(input logic forceIdle);
		logic [31:0] r;
		logic        isInt;
		logic        isLs;
		dataT        opB;

		r = $random(seed);
		fuValid           = forceIdle ? 1'b0 : (r[1:0] != 2'b00);
		fuPacket.fuType   = fuTypeT'(r[4:2]);
		fuPacket.aluOp    = aluOpT'(r[7:5]);
		fuPacket.ldstKind = ldstKindT'(r[8]);
		fuPacket.destReg  = r[13:9];
		fuPacket.warpId   = r[18:14];
		fuMask            = r[22:19];
		r = $random(seed);
		fuPacket.imm = r[15:0];
		for (int l = 0; l < NUM_LANES; l++) begin
			laneOps[l].srcA = $random(seed);
			laneOps[l].srcB = $random(seed);
			laneOps[l].srcC = $random(seed);
		end

		isInt = fuValid && (fuPacket.fuType == FU_INT_R || fuPacket.fuType == FU_INT_I);
		isLs  = fuValid && (fuPacket.fuType == FU_LS);
		expIntuValid = isInt;
		expIntuMask  = isInt ? fuMask : '0;
		expLdstValid = isLs;
		expLdstMask  = isLs ? fuMask : '0;
		expLoad      = isLs && (fuPacket.ldstKind == LDST_LOAD);
		expStore     = isLs && (fuPacket.ldstKind == LDST_STORE);
		if (isInt) begin
			intuSent++;
			expIntuWarp = fuPacket.warpId;
			expIntuDest = fuPacket.destReg;
			for (int l = 0; l < NUM_LANES; l++) begin
				opB = (fuPacket.fuType == FU_INT_I) ? widenImm(fuPacket.imm) : laneOps[l].srcB;
				expIntuData[l] = aluRef(fuPacket.aluOp, laneOps[l].srcA, opB);
			end
		end
		if (isLs) begin
			ldstSent++;
			expLdstWarp = fuPacket.warpId;
			expLdstDest = fuPacket.destReg;
			for (int l = 0; l < NUM_LANES; l++) begin
				expAddr[l]      = laneOps[l].srcA + widenImm(fuPacket.imm);
				expStoreData[l] = laneOps[l].srcB;
			end
		end
	endtask

	task automatic checkOutputs();
		assert (intuValid == expIntuValid)
			else reportMismatch("intuValid", 32'(intuValid), 32'(expIntuValid));
		assert (intuMask == expIntuMask)
			else reportMismatch("intuMask", 32'(intuMask), 32'(expIntuMask));
		assert (ldstValid == expLdstValid)
			else reportMismatch("ldstValid", 32'(ldstValid), 32'(expLdstValid));
		assert (ldstMask == expLdstMask)
			else reportMismatch("ldstMask", 32'(ldstMask), 32'(expLdstMask));
		assert (load == expLoad)
			else reportMismatch("load", 32'(load), 32'(expLoad));
		assert (store == expStore)
			else reportMismatch("store", 32'(store), 32'(expStore));
		if (expIntuValid) begin
			assert (intuWarp == expIntuWarp)
				else reportMismatch("intuWarp", 32'(intuWarp), 32'(expIntuWarp));
			for (int l = 0; l < NUM_LANES; l++) begin
				if (expIntuMask[l]) begin
					assert (intuResults[l].data == expIntuData[l])
						else reportMismatch($sformatf("lane %0d result", l),
							intuResults[l].data, expIntuData[l]);
					assert (intuResults[l].destReg == expIntuDest)
						else reportMismatch($sformatf("lane %0d intu destReg", l),
							32'(intuResults[l].destReg), 32'(expIntuDest));
				end
			end
		end
		if (expLdstValid) begin
			assert (ldstWarp == expLdstWarp)
				else reportMismatch("ldstWarp", 32'(ldstWarp), 32'(expLdstWarp));
			for (int l = 0; l < NUM_LANES; l++) begin
				if (expLdstMask[l]) begin
					assert (ldstRequests[l].addr == expAddr[l])
						else reportMismatch($sformatf("lane %0d addr", l),
							ldstRequests[l].addr, expAddr[l]);
					assert (ldstRequests[l].storeData == expStoreData[l])
						else reportMismatch($sformatf("lane %0d storeData", l),
							ldstRequests[l].storeData, expStoreData[l]);
					assert (ldstRequests[l].destReg == expLdstDest)
						else reportMismatch($sformatf("lane %0d ldst destReg", l),
							32'(ldstRequests[l].destReg), 32'(expLdstDest));
				end
			end
		end
	endtask

	initial begin
		seed     = 32'h01c0_e648;
		arstN    = 1'b0;
		fuValid  = 1'b0;
		fuPacket = '0;
		fuMask   = '0;
		laneOps  = '0;
		clearExpected();

		// all valids and masks stay low while reset is held
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			checkOutputs();
		end
		arstN = 1'b1;
		driveInstruction(1'b1);

		// outputs of the previous drive are checked before the next one
		for (int i = 0; i < NUM_INSTS; i++) begin
			@(negedge clk);
			checkOutputs();
			driveInstruction(1'b0);
		end
		@(negedge clk);
		checkOutputs();

		$display("%0d integer and %0d load/store instructions issued, %0d errors",
			intuSent, ldstSent, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* verification/executeStage_assertions.sv */
// ==================================================
// protocol checks on the execute stage outputs,
// attached to every executeStage instance by bind
// ==================================================
`timescale 1ns/1ps

module executeStageAssertions (
	input  logic                clk,
	input  logic                arstN_i,
	input  logic                fuValid_i,
	input  execPkg::instPacketT fuPacket_i,
	input  logic                intuValid_i,
	input  logic                ldstValid_i,
	input  logic                load_i,
	input  logic                store_i
);
	import execPkg::*;

	logic intuSel;
	logic ldstSel;

	assign intuSel = fuValid_i && (fuPacket_i.fuType == FU_INT_R || fuPacket_i.fuType == FU_INT_I);
	assign ldstSel = fuValid_i && (fuPacket_i.fuType == FU_LS);

	oneClusterOnly: assert property (@(posedge clk) disable iff (!arstN_i)
		!(intuValid_i && ldstValid_i))
		else $error("integer and load/store valid are high together");

	loadOrStoreOnly: assert property (@(posedge clk) disable iff (!arstN_i)
		!(load_i && store_i))
		else $error("load and store are high together");

	kindNeedsValid: assert property (@(posedge clk) disable iff (!arstN_i)
		(load_i || store_i) |-> ldstValid_i)
		else $error("load or store is high without load/store valid");

	// each output valid needs a matching input one cycle before
	intuFollowsInput: assert property (@(posedge clk) disable iff (!arstN_i)
		intuValid_i |-> $past(intuSel))
		else $error("integer valid without an integer instruction one cycle earlier");

	ldstFollowsInput: assert property (@(posedge clk) disable iff (!arstN_i)
		ldstValid_i |-> $past(ldstSel))
		else $error("load/store valid without a load/store instruction one cycle earlier");

endmodule

bind executeStage executeStageAssertions executeStageAssertions_inst (
	.clk         (clk),
	.arstN_i     (arstN_i),
	.fuValid_i   (fuValid_i),
	.fuPacket_i  (fuPacket_i),
	.intuValid_i (intuValid_o),
	.ldstValid_i (ldstValid_o),
	.load_i      (load_o),
	.store_i     (store_o)
);

/* logic/executeStage.sv */
// ==================================================
// execute stage of the SIMT core: dispatch in front
// of the integer and load/store clusters, accepts one
// warp instruction per cycle, results one cycle later
// ==================================================
`timescale 1ns/1ps

module executeStage #(
	parameter int NUM_LANES = 4
) (
	input  logic                                     clk,
	input  logic                                     arstN_i,

	input  logic                                     fuValid_i,
	input  execPkg::instPacketT                      fuPacket_i,
	input  logic [NUM_LANES-1:0]                     fuMask_i,
	input  execPkg::laneOperandsT [NUM_LANES-1:0]    laneOps_i,

	output logic                                     intuValid_o,
	output logic [NUM_LANES-1:0]                     intuMask_o,
	output execPkg::warpIdT                          intuWarp_o,
	output execPkg::intuResultT [NUM_LANES-1:0]      intuResults_o,

	output logic                                     ldstValid_o,
	output logic [NUM_LANES-1:0]                     ldstMask_o,
	output execPkg::warpIdT                          ldstWarp_o,
	output logic                                     load_o,
	output logic                                     store_o,
	output execPkg::ldstRequestT [NUM_LANES-1:0]     ldstRequests_o
);

	logic                 intuIssue;
	logic [NUM_LANES-1:0] intuMask;
	logic                 ldstIssue;
	logic [NUM_LANES-1:0] ldstMask;

	execDispatch #(
		.NUM_LANES (NUM_LANES)
	) execDispatch_inst (
		.fuValid_i   (fuValid_i),
		.fuType_i    (fuPacket_i.fuType),
		.fuMask_i    (fuMask_i),
		.intuIssue_o (intuIssue),
		.intuMask_o  (intuMask),
		.ldstIssue_o (ldstIssue),
		.ldstMask_o  (ldstMask)
	);

	intuCluster #(
		.NUM_LANES (NUM_LANES)
	) intuCluster_inst (
		.clk       (clk),
		.arstN_i   (arstN_i),
		.issue_i   (intuIssue),
		.mask_i    (intuMask),
		.packet_i  (fuPacket_i),
		.laneOps_i (laneOps_i),
		.valid_o   (intuValid_o),
		.mask_o    (intuMask_o),
		.warp_o    (intuWarp_o),
		.results_o (intuResults_o)
	);

	ldstCluster #(
		.NUM_LANES (NUM_LANES)
	) ldstCluster_inst (
		.clk        (clk),
		.arstN_i    (arstN_i),
		.issue_i    (ldstIssue),
		.mask_i     (ldstMask),
		.packet_i   (fuPacket_i),
		.laneOps_i  (laneOps_i),
		.valid_o    (ldstValid_o),
		.mask_o     (ldstMask_o),
		.warp_o     (ldstWarp_o),
		.load_o     (load_o),
		.store_o    (store_o),
		.requests_o (ldstRequests_o)
	);

endmodule

/* logic/ldstCluster.sv */
// ==================================================
// load/store cluster: forms the per-lane address and
// store data and registers the memory request one
// cycle after issue, memory access happens downstream
// ==================================================
`timescale 1ns/1ps

module ldstCluster #(
	parameter int NUM_LANES = 4
) (
	input  logic                                     clk,
	input  logic                                     arstN_i,
	input  logic                                     issue_i,
	input  logic [NUM_LANES-1:0]                     mask_i,
	input  execPkg::instPacketT                      packet_i,
	input  execPkg::laneOperandsT [NUM_LANES-1:0]    laneOps_i,
	output logic                                     valid_o,
	output logic [NUM_LANES-1:0]                     mask_o,
	output execPkg::warpIdT                          warp_o,
	output logic                                     load_o,
	output logic                                     store_o,
	output execPkg::ldstRequestT [NUM_LANES-1:0]     requests_o
);
	import execPkg::*;

	logic isLoad;
	logic isStore;
	dataT offset;
	dataT laneAddr [NUM_LANES];

	assign isLoad  = (packet_i.ldstKind == LDST_LOAD);
	assign isStore = (packet_i.ldstKind == LDST_STORE);

	// every lane shares the same offset from the instruction
	assign offset = signExtImm(packet_i.imm);

	for (genvar lane = 0; lane < NUM_LANES; lane++) begin : genAddr
		assign laneAddr[lane] = laneOps_i[lane].srcA + offset;
	end

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			valid_o <= 1'b0;
			mask_o  <= '0;
			load_o  <= 1'b0;
			store_o <= 1'b0;
		end else begin
			valid_o <= issue_i;
			mask_o  <= mask_i;
			load_o  <= issue_i && isLoad;
			store_o <= issue_i && isStore;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_i) begin
			warp_o <= packet_i.warpId;
			for (int lane = 0; lane < NUM_LANES; lane++) begin
				requests_o[lane].addr      <= laneAddr[lane];
				requests_o[lane].storeData <= laneOps_i[lane].srcB;
				// loads write back into this register later
				requests_o[lane].destReg   <= packet_i.destReg;
			end
		end
	end

endmodule

/* logic/intuCluster.sv */
// ==================================================
// integer cluster: picks operand B per lane, runs
// one ALU per lane and registers the warp result
// one cycle after issue
// ==================================================
`timescale 1ns/1ps

module intuCluster #(
	parameter int NUM_LANES = 4
) (
	input  logic                                     clk,
	input  logic                                     arstN_i,
	input  logic                                     issue_i,
	input  logic [NUM_LANES-1:0]                     mask_i,
	input  execPkg::instPacketT                      packet_i,
	input  execPkg::laneOperandsT [NUM_LANES-1:0]    laneOps_i,
	output logic                                     valid_o,
	output logic [NUM_LANES-1:0]                     mask_o,
	output execPkg::warpIdT                          warp_o,
	output execPkg::intuResultT [NUM_LANES-1:0]      results_o
);
	import execPkg::*;

	logic useImm;
	dataT immExt;
	dataT opB        [NUM_LANES];
	dataT laneResult [NUM_LANES];

	assign useImm = (packet_i.fuType == FU_INT_I);
	assign immExt = signExtImm(packet_i.imm);

	for (genvar lane = 0; lane < NUM_LANES; lane++) begin : genLane
		assign opB[lane] = useImm ? immExt : laneOps_i[lane].srcB;

		intuLane intuLane_inst (
			.aluOp_i  (packet_i.aluOp),
			.opA_i    (laneOps_i[lane].srcA),
			.opB_i    (opB[lane]),
			.result_o (laneResult[lane])
		);
	end

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			valid_o <= 1'b0;
			mask_o  <= '0;
		end else begin
			valid_o <= issue_i;
			mask_o  <= mask_i;
		end
	end

	// payload only moves when an instruction is issued here
	always_ff @(posedge clk) begin
		if (issue_i) begin
			warp_o <= packet_i.warpId;
			for (int lane = 0; lane < NUM_LANES; lane++) begin
				results_o[lane].data    <= laneResult[lane];
				results_o[lane].destReg <= packet_i.destReg;
			end
		end
	end

endmodule

/* logic/intuLane.sv */
// ==================================================
// integer ALU of a single SIMT lane, combinational,
// one copy per lane inside the integer cluster
// ==================================================
`timescale 1ns/1ps

module intuLane (
	input  execPkg::aluOpT aluOp_i,
	input  execPkg::dataT  opA_i,
	input  execPkg::dataT  opB_i,
	output execPkg::dataT  result_o
);
	import execPkg::*;

	// shift amount comes from the low five bits of operand B
	logic [4:0] shiftAmt;

	assign shiftAmt = opB_i[4:0];

	always_comb begin
		case (aluOp_i)
			ALU_ADD: begin
				result_o = opA_i + opB_i;
			end
			ALU_SUB: begin
				result_o = opA_i - opB_i;
			end
			ALU_AND: begin
				result_o = opA_i & opB_i;
			end
			ALU_OR: begin
				result_o = opA_i | opB_i;
			end
			ALU_XOR: begin
				result_o = opA_i ^ opB_i;
			end
			ALU_SHL: begin
				result_o = opA_i << shiftAmt;
			end
			ALU_SHR: begin
				// logical shift, zeros come in from the top
				result_o = opA_i >> shiftAmt;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

/* logic/execDispatch.sv */
// ==================================================
// steers a valid warp instruction to the integer or
// the load/store cluster, purely combinational
// ==================================================
`timescale 1ns/1ps

module execDispatch #(
	parameter int NUM_LANES = 4
) (
	input  logic                 fuValid_i,
	input  execPkg::fuTypeT      fuType_i,
	input  logic [NUM_LANES-1:0] fuMask_i,
	output logic                 intuIssue_o,
	output logic [NUM_LANES-1:0] intuMask_o,
	output logic                 ldstIssue_o,
	output logic [NUM_LANES-1:0] ldstMask_o
);
	import execPkg::*;

	always_comb begin
		intuIssue_o = 1'b0;
		intuMask_o  = '0;
		ldstIssue_o = 1'b0;
		ldstMask_o  = '0;

		// fp and sf types are decoded but have no cluster here
		case (fuType_i)
			FU_INT_R,
			FU_INT_I: begin
				intuIssue_o = fuValid_i;
				if (fuValid_i) begin
					intuMask_o = fuMask_i;
				end
			end
			FU_LS: begin
				ldstIssue_o = fuValid_i;
				if (fuValid_i) begin
					ldstMask_o = fuMask_i;
				end
			end
			default: begin
				intuIssue_o = 1'b0;
				ldstIssue_o = 1'b0;
			end
		endcase
	end

endmodule

/* logic/execPkg.sv */
// ==================================================
// shared widths, field types and packet layouts of
// the execute stage, imported by every RTL module
// ==================================================

package execPkg;

	// lane data and instruction field widths
	parameter int DATA_WIDTH     = 32;
	parameter int REG_ADDR_WIDTH = 5;
	parameter int IMM_WIDTH      = 16;
	parameter int WARP_ID_WIDTH  = 5;

	typedef logic [DATA_WIDTH-1:0]     dataT;
	typedef logic [REG_ADDR_WIDTH-1:0] regAddrT;
	typedef logic [IMM_WIDTH-1:0]      immT;
	typedef logic [WARP_ID_WIDTH-1:0]  warpIdT;

	// functional unit type, code 7 is left unused
	typedef enum logic [2:0] {
		FU_INT_R = 3'd0,
		FU_FP_R  = 3'd1,
		FU_SF_R  = 3'd2,
		FU_INT_I = 3'd3,
		FU_FP_I  = 3'd4,
		FU_SF_I  = 3'd5,
		FU_LS    = 3'd6
	} fuTypeT;

	// integer operation, code 7 yields a zero result
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SHL = 3'd5,
		ALU_SHR = 3'd6
	} aluOpT;

	typedef enum logic {
		LDST_LOAD  = 1'b0,
		LDST_STORE = 1'b1
	} ldstKindT;

	// decoded warp instruction as seen by the execute stage
	typedef struct packed {
		fuTypeT   fuType;
		aluOpT    aluOp;
		ldstKindT ldstKind;
		regAddrT  destReg;
		immT      imm;
		warpIdT   warpId;
	} instPacketT;

	// srcC is carried so the lane layout matches the operand collector
	typedef struct packed {
		dataT srcA;
		dataT srcB;
		dataT srcC;
	} laneOperandsT;

	typedef struct packed {
		dataT    data;
		regAddrT destReg;
	} intuResultT;

	typedef struct packed {
		dataT    addr;
		dataT    storeData;
		regAddrT destReg;
	} ldstRequestT;

	// both clusters widen the immediate the same way
	function automatic dataT signExtImm(immT imm);
		return {{(DATA_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
	endfunction

endpackage
